//--- rv_pipe.f
src/rv_pipe_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/hazard_unit.sv
src/rv_pipe_top.sv
tb/rv_pipe_checker.sv
tb/rv_pipe_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       := rv_pipe_tb
FILELIST  := rv_pipe.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := SOME TESTS FAILED
PASS_MSG  := ALL TESTS PASSED
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/rv_pipe_tb.sv
`timescale 1ns/100ps

module rv_pipe_tb import rv_pipe_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int PROG_LEN   = 18;
    localparam int N_EXP      = 11;
    localparam int DRAIN      = 6;      // Cycles watched for stray retires

    logic                  clk;
    logic                  rst;
    logic [XLEN-1:0]       imem_addr;
    logic [XLEN-1:0]       imem_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    logic [XLEN-1:0]       prog [PROG_LEN];
    logic [REG_ADDR_W-1:0] exp_rd [N_EXP];
    logic [XLEN-1:0]       exp_val [N_EXP];
    logic [29:0]           fetch_word;
    logic [3:0]            exp_idx = '0;

    rv_pipe_top i_dut (
        .clk, .rst, .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata)
    );

    //////////////////////////////
    // RV32I encoders
    function automatic logic [31:0] addi_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                               input int imm);
        return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lw_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                             input int imm);
        return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_instr(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input int imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq_instr(input logic [4:0] rs1, input logic [4:0] rs2,
                                              input int off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic abort_run(input string what);
        $display("%s at %0t ns", what, $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Fail at %0t ns: %s expected 0x%08h, got 0x%08h", $time, sig, expected, actual);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped on a mismatch");
    endtask

    //////////////////////////////
    // Program image and expected retires
    initial begin
        prog[0]  = addi_instr(5'd1, 5'd0, 90);                           // x1 = 0x5A
        prog[1]  = addi_instr(5'd2, 5'd0, 51);                           // x2 = 0x33
        prog[2]  = reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);              // ADD
        prog[3]  = reg_op(7'h20, 3'b000, 5'd4, 5'd2, 5'd3);              // SUB
        prog[4]  = reg_op(7'h00, 3'b111, 5'd5, 5'd4, 5'd3);              // AND
        prog[5]  = reg_op(7'h00, 3'b110, 5'd6, 5'd5, 5'd2);              // OR
        prog[6]  = reg_op(7'h00, 3'b100, 5'd7, 5'd6, 5'd4);              // XOR
        prog[7]  = sw_instr(5'd7, 5'd0, 16);
        prog[8]  = lw_instr(5'd8, 5'd0, 16);
        prog[9]  = reg_op(7'h00, 3'b000, 5'd9, 5'd8, 5'd1);              // Load-use
        prog[10] = addi_instr(5'd0, 5'd0, 7);                            // Writes x0
        prog[11] = beq_instr(5'd9, 5'd8, 8);                             // Not taken
        prog[12] = addi_instr(5'd10, 5'd0, -3);
        prog[13] = beq_instr(5'd1, 5'd1, 12);                            // Taken to 64
        prog[14] = addi_instr(5'd11, 5'd0, 1);                           // Wrong path
        prog[15] = addi_instr(5'd12, 5'd0, 2);                           // Wrong path
        prog[16] = addi_instr(5'd13, 5'd10, 100);
        prog[17] = beq_instr(5'd0, 5'd0, 0);                             // Park here

        exp_rd[0]   = 5'd1;
        exp_val[0]  = 32'h0000_005A;
        exp_rd[1]   = 5'd2;
        exp_val[1]  = 32'h0000_0033;
        exp_rd[2]   = 5'd3;
        exp_val[2]  = 32'h0000_008D;
        exp_rd[3]   = 5'd4;
        exp_val[3]  = 32'hFFFF_FFA6;
        exp_rd[4]   = 5'd5;
        exp_val[4]  = 32'h0000_0084;
        exp_rd[5]   = 5'd6;
        exp_val[5]  = 32'h0000_00B7;
        exp_rd[6]   = 5'd7;
        exp_val[6]  = 32'hFFFF_FF11;
        exp_rd[7]   = 5'd8;
        exp_val[7]  = 32'hFFFF_FF11;
        exp_rd[8]   = 5'd9;
        exp_val[8]  = 32'hFFFF_FF6B;
        exp_rd[9]   = 5'd10;
        exp_val[9]  = 32'hFFFF_FFFD;
        exp_rd[10]  = 5'd13;
        exp_val[10] = 32'h0000_0061;
    end

    // Instruction memory answers in the same cycle
    assign fetch_word = imem_addr[31:2];

    always_comb begin
        if (fetch_word < 30'(PROG_LEN)) begin
            imem_data = prog[fetch_word[4:0]];
        end else begin
            imem_data = 32'h0000_0013;      // ADDI x0,x0,0 past the end
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        wait (exp_idx == 4'(N_EXP));
        repeat (DRAIN) @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

    // Retire port is stable at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            assert (rf_we == 1'b0) else abort_run("Register write seen during reset");
        end else if (rf_we) begin
            assert (exp_idx < 4'(N_EXP))
                else abort_run("A register write retired after the last expected one");
            assert (rf_waddr == exp_rd[exp_idx])
                else report_mismatch("rf_waddr_o", 32'(exp_rd[exp_idx]), 32'(rf_waddr));
            assert (rf_wdata == exp_val[exp_idx])
                else report_mismatch("rf_wdata_o", exp_val[exp_idx], rf_wdata);
            exp_idx <= exp_idx + 4'd1;
        end
    end

    initial begin
        repeat (PROG_LEN * 6 + 20) @(posedge clk);
        abort_run("Watchdog expired before every expected write retired");
    end

endmodule

//--- tb/rv_pipe_checker.sv
`timescale 1ns/100ps

module rv_pipe_checker import rv_pipe_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic [XLEN-1:0]       imem_addr_i,
    input logic                  rf_we_i,
    input logic [REG_ADDR_W-1:0] rf_waddr_i
);

    // Quiet retire port through reset and the cycle after
    reset_quiet: assert property (@(posedge clk) rst |=> !rf_we_i)
        else $error("rf_we_o went high while reset was applied");

    reset_exit_quiet: assert property (@(posedge clk) $past(rst) |=> !rf_we_i)
        else $error("rf_we_o went high in the cycle after reset");

    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        rf_we_i |-> rf_waddr_i != '0)
        else $error("A write to x0 appeared on the retire port");

    fetch_aligned: assert property (@(posedge clk) disable iff (rst)
        imem_addr_i[1:0] == 2'b00)
        else $error("imem_addr_o is not word aligned");

endmodule

bind rv_pipe_top rv_pipe_checker i_checker (
    .clk, .rst, .imem_addr_i(imem_addr_o), .rf_we_i(rf_we_o), .rf_waddr_i(rf_waddr_o)
);

//--- src/rv_pipe_top.sv
`timescale 1ns/100ps

module rv_pipe_top import rv_pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    output logic [XLEN-1:0]       imem_addr_o,
    input  logic [XLEN-1:0]       imem_data_i,
    output logic                  rf_we_o,
    output logic [REG_ADDR_W-1:0] rf_waddr_o,
    output logic [XLEN-1:0]       rf_wdata_o
);

    logic [XLEN-1:0]       id_pc, id_instr;
    logic [REG_ADDR_W-1:0] id_rs1_addr, id_rs2_addr;
    logic [XLEN-1:0]       ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    logic [REG_ADDR_W-1:0] ex_rs1_addr, ex_rs2_addr, ex_rd_addr;
    alu_op_e               ex_alu_op;
    logic                  ex_use_imm, ex_mem_read, ex_mem_write, ex_reg_write, ex_branch;
    logic [XLEN-1:0]       mem_result, mem_store_data;
    logic [REG_ADDR_W-1:0] mem_rd_addr;
    logic                  mem_read, mem_write, mem_reg_write;
    logic                  branch_taken, stall, flush;
    logic [XLEN-1:0]       branch_target;
    fwd_sel_e              fwd_a, fwd_b;

    //////////////////////////////
    // The writeback bus doubles as the retire port
    fetch_stage i_fetch (
        .clk, .rst, .stall_i(stall), .flush_i(flush),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .imem_addr_o, .imem_data_i, .id_pc_o(id_pc), .id_instr_o(id_instr)
    );

    decode_stage i_decode (
        .clk, .rst, .stall_i(stall), .flush_i(flush), .pc_i(id_pc), .instr_i(id_instr),
        .wb_we_i(rf_we_o), .wb_addr_i(rf_waddr_o), .wb_data_i(rf_wdata_o),
        .ex_pc_o(ex_pc), .ex_rs1_data_o(ex_rs1_data), .ex_rs2_data_o(ex_rs2_data),
        .ex_imm_o(ex_imm), .ex_rs1_addr_o(ex_rs1_addr), .ex_rs2_addr_o(ex_rs2_addr),
        .ex_rd_addr_o(ex_rd_addr), .ex_alu_op_o(ex_alu_op), .ex_use_imm_o(ex_use_imm),
        .ex_mem_read_o(ex_mem_read), .ex_mem_write_o(ex_mem_write),
        .ex_reg_write_o(ex_reg_write), .ex_branch_o(ex_branch),
        .id_rs1_addr_o(id_rs1_addr), .id_rs2_addr_o(id_rs2_addr)
    );

    execute_stage i_execute (
        .clk, .rst, .pc_i(ex_pc), .rs1_data_i(ex_rs1_data), .rs2_data_i(ex_rs2_data),
        .imm_i(ex_imm), .rd_addr_i(ex_rd_addr), .alu_op_i(ex_alu_op),
        .use_imm_i(ex_use_imm), .mem_read_i(ex_mem_read), .mem_write_i(ex_mem_write),
        .reg_write_i(ex_reg_write), .branch_i(ex_branch), .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
        .mem_fwd_data_i(mem_result), .wb_fwd_data_i(rf_wdata_o),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .mem_result_o(mem_result), .mem_store_data_o(mem_store_data),
        .mem_rd_addr_o(mem_rd_addr), .mem_read_o(mem_read), .mem_write_o(mem_write),
        .mem_reg_write_o(mem_reg_write)
    );

    memory_stage i_memory (
        .clk, .rst, .result_i(mem_result), .store_data_i(mem_store_data),
        .rd_addr_i(mem_rd_addr), .mem_read_i(mem_read), .mem_write_i(mem_write),
        .reg_write_i(mem_reg_write), .wb_we_o(rf_we_o), .wb_addr_o(rf_waddr_o),
        .wb_data_o(rf_wdata_o)
    );

    hazard_unit i_hazard (
        .id_rs1_addr_i(id_rs1_addr), .id_rs2_addr_i(id_rs2_addr),
        .ex_rd_addr_i(ex_rd_addr), .ex_mem_read_i(ex_mem_read),
        .branch_taken_i(branch_taken), .mem_rd_addr_i(mem_rd_addr),
        .mem_reg_write_i(mem_reg_write), .wb_addr_i(rf_waddr_o), .wb_we_i(rf_we_o),
        .ex_rs1_addr_i(ex_rs1_addr), .ex_rs2_addr_i(ex_rs2_addr),
        .stall_o(stall), .flush_o(flush), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
    );

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit import rv_pipe_pkg::*; (
    input  logic [REG_ADDR_W-1:0] id_rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] id_rs2_addr_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_addr_i,
    input  logic                  ex_mem_read_i,
    input  logic                  branch_taken_i,
    input  logic [REG_ADDR_W-1:0] mem_rd_addr_i,
    input  logic                  mem_reg_write_i,
    input  logic [REG_ADDR_W-1:0] wb_addr_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] ex_rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] ex_rs2_addr_i,
    output logic                  stall_o,
    output logic                  flush_o,
    output fwd_sel_e              fwd_a_o,
    output fwd_sel_e              fwd_b_o
);

    // Youngest producer wins
    function automatic fwd_sel_e fwd_pick(input logic [REG_ADDR_W-1:0] rs,
                                          input logic mem_we, input logic [REG_ADDR_W-1:0] mem_rd,
                                          input logic wb_we, input logic [REG_ADDR_W-1:0] wb_rd);
        if (rs == '0) begin
            return FWD_REG;
        end else if (mem_we && mem_rd == rs) begin
            return FWD_MEM;
        end else if (wb_we && wb_rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwd_a_o = fwd_pick(ex_rs1_addr_i, mem_reg_write_i, mem_rd_addr_i, wb_we_i, wb_addr_i);
    assign fwd_b_o = fwd_pick(ex_rs2_addr_i, mem_reg_write_i, mem_rd_addr_i, wb_we_i, wb_addr_i);

    // Load result is one cycle too late for the next instruction
    assign stall_o = ex_mem_read_i && (ex_rd_addr_i != '0) &&
                     (ex_rd_addr_i == id_rs1_addr_i || ex_rd_addr_i == id_rs2_addr_i);

    assign flush_o = branch_taken_i;    // Kills decode and fetch slots

endmodule

//--- src/memory_stage.sv
`timescale 1ns/100ps

module memory_stage import rv_pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [XLEN-1:0]       result_i,
    input  logic [XLEN-1:0]       store_data_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic                  mem_read_i,
    input  logic                  mem_write_i,
    input  logic                  reg_write_i,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_addr_o,
    output logic [XLEN-1:0]       wb_data_o
);

    logic [XLEN-1:0]       dmem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] word_idx;
    logic [XLEN-1:0]       load_data;

    // Upper address bits wrap around the array
    assign word_idx  = result_i[DMEM_IDX_W+1:2];
    assign load_data = dmem[word_idx];

    always_ff @(posedge clk) begin
        if (mem_write_i) begin
            dmem[word_idx] <= store_data_i;
        end
    end

    //////////////////////////////
    // MEM/WB register
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= reg_write_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= rd_addr_i;
        wb_data_o <= mem_read_i ? load_data : result_i;
    end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import rv_pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  alu_op_e               alu_op_i,
    input  logic                  use_imm_i,
    input  logic                  mem_read_i,
    input  logic                  mem_write_i,
    input  logic                  reg_write_i,
    input  logic                  branch_i,
    input  fwd_sel_e              fwd_a_i,
    input  fwd_sel_e              fwd_b_i,
    input  logic [XLEN-1:0]       mem_fwd_data_i,
    input  logic [XLEN-1:0]       wb_fwd_data_i,
    output logic                  branch_taken_o,
    output logic [XLEN-1:0]       branch_target_o,
    output logic [XLEN-1:0]       mem_result_o,
    output logic [XLEN-1:0]       mem_store_data_o,
    output logic [REG_ADDR_W-1:0] mem_rd_addr_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o,
    output logic                  mem_reg_write_o
);

    logic [XLEN-1:0] op_a, op_b, alu_b, alu_result;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                input logic [XLEN-1:0] reg_data,
                                                input logic [XLEN-1:0] mem_data,
                                                input logic [XLEN-1:0] wb_data);
        case (sel)
            FWD_MEM: return mem_data;
            FWD_WB:  return wb_data;
            default: return reg_data;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a_i, rs1_data_i, mem_fwd_data_i, wb_fwd_data_i);
    assign op_b  = fwd_mux(fwd_b_i, rs2_data_i, mem_fwd_data_i, wb_fwd_data_i);
    assign alu_b = use_imm_i ? imm_i : op_b;

    always_comb begin
        case (alu_op_i)
            ALU_SUB: alu_result = op_a - alu_b;
            ALU_AND: alu_result = op_a & alu_b;
            ALU_OR:  alu_result = op_a | alu_b;
            ALU_XOR: alu_result = op_a ^ alu_b;
            default: alu_result = op_a + alu_b;
        endcase
    end

    // BEQ resolves here
    assign branch_taken_o  = branch_i && (op_a == op_b);
    assign branch_target_o = pc_i + imm_i;

    //////////////////////////////
    // EX/MEM register
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_read_o      <= 1'b0;
            mem_write_o     <= 1'b0;
            mem_reg_write_o <= 1'b0;
        end else begin
            mem_read_o      <= mem_read_i;
            mem_write_o     <= mem_write_i;
            mem_reg_write_o <= reg_write_i;
        end
    end

    always_ff @(posedge clk) begin
        mem_result_o     <= alu_result;
        mem_store_data_o <= op_b;       // Forwarded store data
        mem_rd_addr_o    <= rd_addr_i;
    end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import rv_pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       instr_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_addr_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output logic [XLEN-1:0]       ex_pc_o,
    output logic [XLEN-1:0]       ex_rs1_data_o,
    output logic [XLEN-1:0]       ex_rs2_data_o,
    output logic [XLEN-1:0]       ex_imm_o,
    output logic [REG_ADDR_W-1:0] ex_rs1_addr_o,
    output logic [REG_ADDR_W-1:0] ex_rs2_addr_o,
    output logic [REG_ADDR_W-1:0] ex_rd_addr_o,
    output alu_op_e               ex_alu_op_o,
    output logic                  ex_use_imm_o,
    output logic                  ex_mem_read_o,
    output logic                  ex_mem_write_o,
    output logic                  ex_reg_write_o,
    output logic                  ex_branch_o,
    output logic [REG_ADDR_W-1:0] id_rs1_addr_o,
    output logic [REG_ADDR_W-1:0] id_rs2_addr_o
);

    opcode_e               opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data, imm;
    alu_op_e               alu_op;
    logic                  use_imm, mem_read, mem_write, reg_write, branch, rs2_used;
    logic [XLEN-1:0]       regs [1:2**REG_ADDR_W-1];    // x0 is not stored

    assign opcode   = opcode_e'(instr_i[OPCODE_W-1:0]);
    assign funct3   = instr_i[FUNCT3_LSB +: FUNCT3_W];
    assign rs1_addr = instr_i[RS1_LSB +: REG_ADDR_W];
    assign rd_addr  = instr_i[RD_LSB +: REG_ADDR_W];
    assign rs2_addr = rs2_used ? instr_i[RS2_LSB +: REG_ADDR_W] : '0;   // Avoids false stalls

    assign id_rs1_addr_o = rs1_addr;
    assign id_rs2_addr_o = rs2_addr;

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        branch    = 1'b0;
        rs2_used  = 1'b0;
        imm       = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};    // I-type
        case (opcode)
            OP_REG: begin
                reg_write = 1'b1;
                rs2_used  = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op = instr_i[FUNCT7_SUB_BIT] ? ALU_SUB : ALU_ADD;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    alu_op = ALU_ADD;
                endcase
            end
            OP_IMM: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LOAD: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            OP_STORE: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
                rs2_used  = 1'b1;
                imm = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            OP_BRANCH: begin
                branch   = 1'b1;
                rs2_used = 1'b1;
                imm = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
            end
            default: ;  // Unsupported opcodes run as bubbles
        endcase
    end

    //////////////////////////////
    // Register file
    function automatic logic [XLEN-1:0] rf_read(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_we_i && wb_addr_i == addr) begin
            return wb_data_i;   // Same-cycle writeback
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = rf_read(rs1_addr);
        rs2_data = rf_read(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (wb_we_i && wb_addr_i != '0) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    //////////////////////////////
    // ID/EX register
    always_ff @(posedge clk) begin
        if (rst || stall_i || flush_i) begin
            ex_mem_read_o  <= 1'b0;
            ex_mem_write_o <= 1'b0;
            ex_reg_write_o <= 1'b0;
            ex_branch_o    <= 1'b0;
        end else begin
            ex_mem_read_o  <= mem_read;
            ex_mem_write_o <= mem_write;
            ex_reg_write_o <= reg_write && (rd_addr != '0);   // x0 never retires
            ex_branch_o    <= branch;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o       <= pc_i;
        ex_rs1_data_o <= rs1_data;
        ex_rs2_data_o <= rs2_data;
        ex_imm_o      <= imm;
        ex_rs1_addr_o <= rs1_addr;
        ex_rs2_addr_o <= rs2_addr;
        ex_rd_addr_o  <= rd_addr;
        ex_alu_op_o   <= alu_op;
        ex_use_imm_o  <= use_imm;
    end

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage import rv_pipe_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic            branch_taken_i,
    input  logic [XLEN-1:0] branch_target_i,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [XLEN-1:0] imem_data_i,
    output logic [XLEN-1:0] id_pc_o,
    output logic [XLEN-1:0] id_instr_o
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;

    assign imem_addr_o = pc;

    // Redirect wins over a stall
    always_comb begin
        if (branch_taken_i) begin
            pc_next = branch_target_i;
        end else if (stall_i) begin
            pc_next = pc;
        end else begin
            pc_next = pc + XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    //////////////////////////////
    // IF/ID register
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            id_instr_o <= NOP_INSTR;    // Wrong-path slot becomes a bubble
        end else if (!stall_i) begin
            id_instr_o <= imem_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            id_pc_o <= pc;
        end
    end

endmodule

//--- src/rv_pipe_pkg.sv
package rv_pipe_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    //////////////////////////////
    // Instruction fields
    localparam int OPCODE_W       = 7;
    localparam int RD_LSB         = 7;
    localparam int FUNCT3_LSB     = 12;
    localparam int FUNCT3_W       = 3;
    localparam int RS1_LSB        = 15;
    localparam int RS2_LSB        = 20;
    localparam int FUNCT7_SUB_BIT = 30;     // Selects SUB over ADD

    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    // ADDI x0,x0,0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    typedef enum logic [OPCODE_W-1:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR
    } alu_op_e;

    // Operand source for execute
    typedef enum logic [1:0] {
        FWD_REG, FWD_MEM, FWD_WB
    } fwd_sel_e;

endpackage
